//--- verilog/anc_settings.svh
// relay times are counted in tick_ms pulses (1 ms each); tick counters must hold the longest time
`ifndef ANC_SETTINGS_SVH
`define ANC_SETTINGS_SVH

// ------------------------------------------------------------------------
// G-15 level lines and I/O Writer magnets
// ------------------------------------------------------------------------
`define ANC_LEVELS          5   // lev1..lev5 from the G-15
`define ANC_MAG_COUNT       47  // typebars 0..43, then cr, tab, space
`define ANC_MAG_CR          44  // carriage return magnet
`define ANC_MAG_TAB         45  // tab magnet
`define ANC_MAG_SPACE       46  // space bar magnet

// ------------------------------------------------------------------------
// relay timing in ms ticks
// ------------------------------------------------------------------------
`define ANC_TICK_W          5   // up to 31 ticks per transition
`define ANC_LEV_MAKE_TICKS  10  // level relay pull-in
`define ANC_LEV_BREAK_TICKS 20  // level relay release, slowed by diode bypass
`define ANC_CTL_MAKE_TICKS  10  // type and exc relay pull-in
`define ANC_CTL_BREAK_TICKS 10  // type and exc relay release

`endif

//--- verilog/anc_pkg.sv
// numeric output path only; widths here track the counts in anc_settings.svh

package anc_pkg;

    // ------------------------------------------------------------------------
    // vectors that carry a meaning
    // ------------------------------------------------------------------------

    // one bit per G-15 level line
    typedef logic [4:0] level_code_t;   // bit 0 is lev1, bit 4 is lev5

    // one bit per I/O Writer magnet
    typedef logic [46:0] magnet_vec_t;  // 0..43 typebars, 44 cr, 45 tab, 46 space

    // relay transition timer
    typedef logic [4:0] tick_count_t;   // counts tick_ms pulses

    // ------------------------------------------------------------------------
    // relay contact state
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        rly_open     = 2'b00,  // coil off, contact open
        rly_making   = 2'b01,  // coil on, pull-in running
        rly_made     = 2'b11,  // coil on, contact closed
        rly_breaking = 2'b10   // coil off, release running
    } relay_state_e;

endpackage

//--- verilog/coupler_relay.sv
// tick_ms must be a one-clock pulse; make and break times must be 1..31 ticks
`timescale 1ns/1ns

`include "anc_settings.svh"

module coupler_relay
    import anc_pkg::*;
#(
    parameter int unsigned make_ticks  = `ANC_CTL_MAKE_TICKS,  // pull-in time
    parameter int unsigned break_ticks = `ANC_CTL_BREAK_TICKS  // release time
) (
    input  logic CLOCK,
    input  logic rst_n,
    input  logic tick_ms,   // 1 ms strobe
    input  logic enable,    // coil drive
    output logic made       // contact closed
);

    // last count before the contact moves
    localparam tick_count_t make_last  = `ANC_TICK_W'(make_ticks - 1);
    localparam tick_count_t break_last = `ANC_TICK_W'(break_ticks - 1);

    relay_state_e state, state_nxt;
    tick_count_t  count, count_nxt;
    logic         make_due;   // pull-in completes on this edge
    logic         break_due;  // release completes on this edge

    assign make_due  = tick_ms && (count == make_last);
    assign break_due = tick_ms && (count == break_last);

    // ------------------------------------------------------------------------
    // coil vs contact; count only while they disagree
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        count_nxt = '0;                               // cleared when coil matches
        case (state)
            rly_open, rly_making: begin
                if (!enable) begin
                    state_nxt = rly_open;             // short pulse filtered out
                end else if (make_due) begin
                    state_nxt = rly_made;             // armature pulled in
                end else begin
                    state_nxt = rly_making;
                    count_nxt = count + tick_count_t'(tick_ms);
                end
            end
            rly_made, rly_breaking: begin
                if (enable) begin
                    state_nxt = rly_made;             // coil back on, release cancelled
                end else if (break_due) begin
                    state_nxt = rly_open;             // spring pulls contact open
                end else begin
                    state_nxt = rly_breaking;
                    count_nxt = count + tick_count_t'(tick_ms);
                end
            end
            default: begin
                state_nxt = rly_open;
            end
        endcase
    end

    always_ff @(posedge CLOCK) begin
        if (!rst_n) begin
            state <= rly_open;                        // all contacts open after reset
            count <= '0;
        end else begin
            state <= state_nxt;
            count <= count_nxt;
        end
    end

    // contact is closed in made and while release is still running
    assign made = (state == rly_made) || (state == rly_breaking);

endmodule

//--- verilog/type_strobe_gate.sv
// TYPE must stay up for a whole output line; no alpha mode, no input-writer paths
`timescale 1ns/1ns

`include "anc_settings.svh"

module type_strobe_gate
    import anc_pkg::*;
(
    input  logic        CLOCK,
    input  logic        rst_n,
    input  logic        tick_ms,     // 1 ms strobe
    input  logic        type_in,     // G-15 TYPE, held for the line
    input  logic        exc_in,      // G-15 EXC character strobe
    input  logic        ilk,         // typewriter space/cr/tab interlock contact
    input  level_code_t lev_in,      // G-15 level lines
    output level_code_t lev_enable,  // coil drive to the level relays
    output logic        exc_made,    // exc relay contact
    output logic        lev3_fb      // interlock back to the G-15 on lev3
);

    logic type_made;   // type relay contact
    logic exc_enable;  // exc relay coil

    // ------------------------------------------------------------------------
    // type relay buffers the G-15 TYPE line
    // ------------------------------------------------------------------------
    coupler_relay #(
        .make_ticks  (`ANC_CTL_MAKE_TICKS),
        .break_ticks (`ANC_CTL_BREAK_TICKS)
    ) type_relay (
        .CLOCK   (CLOCK),
        .rst_n   (rst_n),
        .tick_ms (tick_ms),
        .enable  (type_in),
        .made    (type_made)
    );

    // ------------------------------------------------------------------------
    // exc relay, coil fed through the type contact
    // ------------------------------------------------------------------------
    assign exc_enable = type_made & exc_in;  // no strobe unless typing

    coupler_relay #(
        .make_ticks  (`ANC_CTL_MAKE_TICKS),
        .break_ticks (`ANC_CTL_BREAK_TICKS)
    ) exc_relay (
        .CLOCK   (CLOCK),
        .rst_n   (rst_n),
        .tick_ms (tick_ms),
        .enable  (exc_enable),
        .made    (exc_made)   // decoder only fires while this is closed
    );

    // ------------------------------------------------------------------------
    // level coils and lev3 feedback through the type contact
    // ------------------------------------------------------------------------
    // level coils see the G-15 lines only while typing
    assign lev_enable = lev_in & {`ANC_LEVELS{type_made}};

    // space, cr and tab hold ilk closed while the carriage moves,
    // the G-15 waits on lev3 before the next character
    assign lev3_fb = type_made & ilk;

endmodule

//--- verilog/numeric_magnet_decoder.sv
// hex numeric codes only; at most one magnet per code, no shift magnet driven
`timescale 1ns/1ns

`include "anc_settings.svh"

module numeric_magnet_decoder
    import anc_pkg::*;
(
    input  level_code_t lev_made,  // level relay contacts, lev5 in bit 4
    input  logic        exc_made,  // exc relay contact
    output magnet_vec_t mag        // typewriter magnet drive
);

    // control magnets and the no-magnet marker
    localparam logic [5:0] mag_cr    = 6'(`ANC_MAG_CR);
    localparam logic [5:0] mag_tab   = 6'(`ANC_MAG_TAB);
    localparam logic [5:0] mag_space = 6'(`ANC_MAG_SPACE);
    localparam logic [5:0] mag_none  = 6'(`ANC_MAG_COUNT);  // one past the last magnet

    logic [5:0] mag_idx;  // selected magnet
    logic       mag_hit;  // a magnet fires

    // ------------------------------------------------------------------------
    // code to magnet number, diode matrix in the coupler
    // ------------------------------------------------------------------------
    always_comb begin
        mag_idx = mag_none;
        if (lev_made[4]) begin
            // lev5 set, digits and u..z
            case (lev_made[3:0])
                4'd0:    mag_idx = 6'd35;  // 0 )
                4'd1:    mag_idx = 6'd39;  // 1
                4'd2:    mag_idx = 6'd3;   // 2 +
                4'd3:    mag_idx = 6'd7;   // 3
                4'd4:    mag_idx = 6'd11;  // 4 $
                4'd5:    mag_idx = 6'd15;  // 5 =
                4'd6:    mag_idx = 6'd19;  // 6
                4'd7:    mag_idx = 6'd23;  // 7 [
                4'd8:    mag_idx = 6'd27;  // 8 ]
                4'd9:    mag_idx = 6'd31;  // 9 (
                4'd10:   mag_idx = 6'd25;  // u, hex ten
                4'd11:   mag_idx = 6'd16;  // v, hex eleven
                4'd12:   mag_idx = 6'd5;   // w
                4'd13:   mag_idx = 6'd8;   // x
                4'd14:   mag_idx = 6'd21;  // y
                4'd15:   mag_idx = 6'd4;   // z
                default: mag_idx = mag_none;
            endcase
        end else begin
            // lev5 clear, lev4 not wired in this half of the matrix
            case (lev_made[2:0])
                3'b000:  mag_idx = mag_space;  // space
                3'b001:  mag_idx = 6'd43;      // minus sign
                3'b010:  mag_idx = mag_cr;     // carriage return
                3'b011:  mag_idx = mag_tab;    // tab
                3'b110:  mag_idx = 6'd36;      // period
                default: mag_idx = mag_none;   // 100, 101, 111 type nothing
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // magnet drive through the exc contact
    // ------------------------------------------------------------------------
    assign mag_hit = exc_made && (mag_idx != mag_none);

    always_comb begin
        mag = '0;                   // all magnets off between strobes
        if (mag_hit) begin
            mag[mag_idx] = 1'b1;    // single typebar or control magnet
        end
    end

endmodule

//--- verilog/anc_output_writer.sv
// output writer only, numeric mode; the G-15 paces by timing, no back-pressure
`timescale 1ns/1ns

`include "anc_settings.svh"

module anc_output_writer
    import anc_pkg::*;
(
    input  logic        CLOCK,
    input  logic        rst_n,
    input  logic        tick_ms,  // 1 ms strobe
    input  logic        type_in,  // G-15 TYPE
    input  logic        exc_in,   // G-15 EXC
    input  logic        ilk,      // space/cr/tab interlock
    input  level_code_t lev_in,   // G-15 level lines
    output magnet_vec_t mag,      // I/O Writer magnets
    output logic        lev3_fb   // interlock feedback on lev3
);

    level_code_t lev_enable;  // gated level coils
    level_code_t lev_made;    // level relay contacts
    logic        exc_made;    // exc relay contact

    // ------------------------------------------------------------------------
    // type/exc relays and TYPE gating
    // ------------------------------------------------------------------------
    type_strobe_gate type_strobe_gate_inst (
        .CLOCK      (CLOCK),
        .rst_n      (rst_n),
        .tick_ms    (tick_ms),
        .type_in    (type_in),
        .exc_in     (exc_in),
        .ilk        (ilk),
        .lev_in     (lev_in),
        .lev_enable (lev_enable),
        .exc_made   (exc_made),
        .lev3_fb    (lev3_fb)
    );

    // ------------------------------------------------------------------------
    // level relays, slow release so exc breaks the magnet current first
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `ANC_LEVELS; i++) begin : g_lev_relay
        coupler_relay #(
            .make_ticks  (`ANC_LEV_MAKE_TICKS),
            .break_ticks (`ANC_LEV_BREAK_TICKS)  // diode bypass on the coil
        ) lev_relay (
            .CLOCK   (CLOCK),
            .rst_n   (rst_n),
            .tick_ms (tick_ms),
            .enable  (lev_enable[i]),
            .made    (lev_made[i])
        );
    end

    // ------------------------------------------------------------------------
    // code to magnet
    // ------------------------------------------------------------------------
    numeric_magnet_decoder numeric_magnet_decoder_inst (
        .lev_made (lev_made),
        .exc_made (exc_made),
        .mag      (mag)
    );

endmodule

//--- tb/anc_char_table.svh
// row index equals the level code; included inside the testbench module after the package import
`ifndef ANC_CHAR_TABLE_SVH
`define ANC_CHAR_TABLE_SVH

// columns: level code (b5..b1), magnet expected, magnet index
typedef struct packed {
    level_code_t code;     // lev5 in bit 4
    logic        has_mag;  // a magnet fires for this code
    logic [5:0]  mag_idx;  // don't care when has_mag is clear
} char_row_t;

char_row_t char_table [0:31] = '{
    '{5'h00, 1'b1, 6'd46},  // space
    '{5'h01, 1'b1, 6'd43},  // minus
    '{5'h02, 1'b1, 6'd44},  // cr
    '{5'h03, 1'b1, 6'd45},  // tab
    '{5'h04, 1'b0, 6'd0},   // nothing
    '{5'h05, 1'b0, 6'd0},   // nothing
    '{5'h06, 1'b1, 6'd36},  // period
    '{5'h07, 1'b0, 6'd0},   // nothing
    '{5'h08, 1'b1, 6'd46},  // b4 ignored from here, space
    '{5'h09, 1'b1, 6'd43},  // minus
    '{5'h0a, 1'b1, 6'd44},  // cr
    '{5'h0b, 1'b1, 6'd45},  // tab
    '{5'h0c, 1'b0, 6'd0},
    '{5'h0d, 1'b0, 6'd0},
    '{5'h0e, 1'b1, 6'd36},  // period
    '{5'h0f, 1'b0, 6'd0},
    '{5'h10, 1'b1, 6'd35},  // digit 0
    '{5'h11, 1'b1, 6'd39},  // 1
    '{5'h12, 1'b1, 6'd3},   // 2
    '{5'h13, 1'b1, 6'd7},   // 3
    '{5'h14, 1'b1, 6'd11},  // 4
    '{5'h15, 1'b1, 6'd15},  // 5
    '{5'h16, 1'b1, 6'd19},  // 6
    '{5'h17, 1'b1, 6'd23},  // 7
    '{5'h18, 1'b1, 6'd27},  // 8
    '{5'h19, 1'b1, 6'd31},  // 9
    '{5'h1a, 1'b1, 6'd25},  // u
    '{5'h1b, 1'b1, 6'd16},  // v
    '{5'h1c, 1'b1, 6'd5},   // w
    '{5'h1d, 1'b1, 6'd8},   // x
    '{5'h1e, 1'b1, 6'd21},  // y
    '{5'h1f, 1'b1, 6'd4}    // z
};

`endif

//--- tb/tb_anc_output_writer.sv
// windows assume tick_ms every tick_clks clocks and level break >= make; random order from seed 35
`timescale 1ns/1ns

`include "anc_settings.svh"

module tb_anc_output_writer
    import anc_pkg::*;
();

    // ------------------------------------------------------------------------
    // timing windows in clocks unless named ticks
    // ------------------------------------------------------------------------
    localparam int clk_period     = 10;
    localparam int tick_clks      = 4;                  // clocks per tick_ms pulse
    localparam int row_count      = 32;
    localparam int lev_settle     = (`ANC_LEV_BREAK_TICKS > `ANC_LEV_MAKE_TICKS) ?
                                    `ANC_LEV_BREAK_TICKS : `ANC_LEV_MAKE_TICKS;
    localparam int settle_clks    = (`ANC_CTL_MAKE_TICKS + lev_settle) * tick_clks + 4;
    localparam int exc_make_clks  = `ANC_CTL_MAKE_TICKS * tick_clks + 2;
    localparam int exc_break_clks = `ANC_CTL_BREAK_TICKS * tick_clks + 2;
    localparam int short_max_clks = (`ANC_CTL_MAKE_TICKS - 2) * tick_clks;  // filtered pulse
    localparam int hold_max_ticks = 4;
    localparam int gap_max_ticks  = 4;
    localparam int char_clks      = settle_clks + exc_make_clks + hold_max_ticks * tick_clks
                                    + exc_break_clks + gap_max_ticks * tick_clks;
    localparam int watchdog_ns    = (row_count + 12) * char_clks * clk_period;

    logic        CLOCK;
    logic        rst_n;
    logic        tick_ms;
    logic        type_in;
    logic        exc_in;
    logic        ilk;
    level_code_t lev_in;
    magnet_vec_t mag;
    logic        lev3_fb;

    int value_errors   = 0;
    int timeout_errors = 0;
    int tick_div;

    `include "anc_char_table.svh"

    anc_output_writer anc_output_writer_inst (
        .CLOCK   (CLOCK),
        .rst_n   (rst_n),
        .tick_ms (tick_ms),
        .type_in (type_in),
        .exc_in  (exc_in),
        .ilk     (ilk),
        .lev_in  (lev_in),
        .mag     (mag),
        .lev3_fb (lev3_fb)
    );

    initial begin
        CLOCK = 1'b0;
        forever begin
            #(clk_period / 2);
            CLOCK = ~CLOCK;
        end
    end

    // one-clock ms strobe
    initial begin
        tick_ms  = 1'b0;
        tick_div = 0;
        forever begin
            @(posedge CLOCK);
            #1;
            tick_div = (tick_div == tick_clks - 1) ? 0 : tick_div + 1;
            tick_ms  = (tick_div == tick_clks - 1);
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic next_clock();
        @(posedge CLOCK);
        #1;                                   // drive and sample point
    endtask

    task automatic report_value_error(input string msg);
        value_errors++;
        $display("error at %0t ns: %s (mag=%h lev3_fb=%b)", $time, msg, mag, lev3_fb);
    endtask

    task automatic report_timeout(input string msg);
        timeout_errors++;
        $display("%s at %0t ns", msg, $time);
    endtask

    task automatic print_counts();
        $display("errors: %0d wrong value, %0d timeout", value_errors, timeout_errors);
    endtask

    // no magnet may be set for n clocks
    task automatic expect_idle(input int n, input string what);
        int i;
        for (i = 0; i < n; i++) begin
            next_clock();
            assert (mag == '0) else report_value_error($sformatf("magnet set %s", what));
        end
    endtask

    task automatic wait_for_magnet(input magnet_vec_t expect_vec, output bit rose);
        int i;
        rose = 1'b0;
        for (i = 0; i < exc_make_clks && !rose; i++) begin
            next_clock();
            assert (mag == '0 || mag == expect_vec)
                else report_value_error("wrong magnet while exc making");
            rose = (mag == expect_vec);
        end
    endtask

    // once zero, mag stays zero for the rest of the break window
    task automatic wait_for_release(input magnet_vec_t expect_vec);
        bit released;
        int i;
        released = 1'b0;
        for (i = 0; i < exc_break_clks; i++) begin
            next_clock();
            assert (mag == '0 || (!released && mag == expect_vec))
                else report_value_error("magnet set after exc release");
            if (mag == '0) begin
                released = 1'b1;
            end
        end
        if (!released) begin
            report_timeout("magnet never released after exc dropped");
        end
    endtask

    // ------------------------------------------------------------------------
    // one character through the full G-15 handshake
    // ------------------------------------------------------------------------
    task automatic type_row(input int row, input int hold_ticks, input int gap_ticks);
        magnet_vec_t expect_vec;
        bit          rose;
        int          i;
        expect_vec = '0;
        if (char_table[row].has_mag) begin
            expect_vec[char_table[row].mag_idx] = 1'b1;
        end
        type_in = 1'b1;                       // held for the whole line
        lev_in  = char_table[row].code;
        expect_idle(settle_clks, "before exc");
        exc_in = 1'b1;
        if (char_table[row].has_mag) begin
            wait_for_magnet(expect_vec, rose);
            if (!rose) begin
                report_timeout($sformatf("magnet never rose for code %02h", lev_in));
            end
            for (i = 0; i < hold_ticks * tick_clks; i++) begin
                next_clock();
                assert (!rose || mag == expect_vec)
                    else report_value_error("magnet changed while exc held");
            end
        end else begin
            expect_idle(exc_make_clks + hold_ticks * tick_clks, "for a no-magnet code");
        end
        exc_in = 1'b0;
        wait_for_release(expect_vec);
        expect_idle(gap_ticks * tick_clks, "between characters");  // lev_in may change after
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int order [0:row_count-1];
        int pick;
        int swap;
        int n;
        void'($urandom(35));
        rst_n   = 1'b0;
        type_in = 1'b0;
        exc_in  = 1'b0;
        ilk     = 1'b1;                       // interlock closed through reset
        lev_in  = '0;
        repeat (4) @(posedge CLOCK);
        #1;
        rst_n = 1'b1;
        next_clock();
        assert (mag == '0 && lev3_fb == 1'b0)
            else report_value_error("outputs not idle after reset");

        // shuffled table order
        for (n = 0; n < row_count; n++) begin
            order[n] = n;
        end
        for (n = row_count - 1; n > 0; n--) begin
            pick        = $urandom_range(n, 0);
            swap        = order[n];
            order[n]    = order[pick];
            order[pick] = swap;
        end
        for (n = 0; n < row_count; n++) begin
            type_row(order[n], $urandom_range(hold_max_ticks, 1), $urandom_range(gap_max_ticks, 1));
        end

        // interlock feedback while type is made
        ilk = 1'b1;
        next_clock();
        assert (lev3_fb == 1'b1) else report_value_error("lev3_fb not following ilk");
        ilk = 1'b0;
        next_clock();
        assert (lev3_fb == 1'b0) else report_value_error("lev3_fb not following ilk");

        // type released so feedback and strobes are blocked
        type_in = 1'b0;
        expect_idle(exc_break_clks, "during type release");
        for (n = 0; n < 8; n++) begin
            ilk = ~ilk;
            next_clock();
            assert (lev3_fb == 1'b0) else report_value_error("lev3_fb high with type released");
        end
        for (n = 0; n < 4; n++) begin
            lev_in = level_code_t'($urandom_range(31, 0));
            exc_in = 1'b1;
            expect_idle(exc_make_clks + 2 * tick_clks, "with type released");
            exc_in = 1'b0;
            expect_idle(exc_break_clks, "after exc with type released");
        end

        // short exc pulses must be filtered by the exc relay
        type_in = 1'b1;
        for (n = 0; n < 3; n++) begin
            lev_in = char_table[$urandom_range(31, 16)].code;  // b5 set, always a magnet
            expect_idle(settle_clks, "before short exc");
            exc_in = 1'b1;
            expect_idle($urandom_range(short_max_clks, 1), "during short exc");
            exc_in = 1'b0;
            expect_idle(exc_make_clks, "after short exc");
        end

        print_counts();
        if (value_errors + timeout_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // run limit from table length times worst character window
    initial begin
        #(watchdog_ns);
        report_timeout("watchdog expired, run took too long");
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
+incdir+tb
verilog/anc_pkg.sv
verilog/coupler_relay.sv
verilog/type_strobe_gate.sv
verilog/numeric_magnet_decoder.sv
verilog/anc_output_writer.sv
tb/tb_anc_output_writer.sv
